//--- rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN    = 64;
    localparam int REG_AW  = 5;
    localparam int INSTR_W = 32;

    // major opcodes handled by the decoder
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011; // addw, subw, ...
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011; // addiw, ...
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;

    typedef struct packed {
        logic [6:0]        funct7;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]       imm;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } i_fmt_t;

    // one instruction word, viewed as R or I format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

endpackage

`default_nettype wire

//--- fwd_pkg.sv
`default_nettype none

package fwd_pkg;

    // how an EX result is widened before forwarding
    localparam int EXT_W = 2;

    localparam logic [EXT_W-1:0] EXT_NONE   = 2'd0; // full 64 bits
    localparam logic [EXT_W-1:0] EXT_WORD_S = 2'd1; // sext 31:0
    localparam logic [EXT_W-1:0] EXT_WORD_Z = 2'd2; // zext 31:0
    localparam logic [EXT_W-1:0] EXT_HALF_S = 2'd3; // sext 15:0

    // where an operand value was taken from
    localparam int SRC_W = 3;

    localparam logic [SRC_W-1:0] SRC_ZERO = 3'd0;
    localparam logic [SRC_W-1:0] SRC_EX   = 3'd1;
    localparam logic [SRC_W-1:0] SRC_MEM  = 3'd2;
    localparam logic [SRC_W-1:0] SRC_WB   = 3'd3;
    localparam logic [SRC_W-1:0] SRC_RF   = 3'd4;

endpackage

`default_nettype wire

//--- operand_decode.sv
`timescale 1ns/1ps
`default_nettype none

module operand_decode
    import rv_isa_pkg::*;
(
    input  instr_u            instr,
    output logic [REG_AW-1:0] rs1,
    output logic [REG_AW-1:0] rs2,
    output logic [REG_AW-1:0] rd,
    output logic              uses_rs2,
    output logic [XLEN-1:0]   imm
);

    always_comb begin
        rs1      = '0;
        rs2      = '0;
        rd       = '0;
        uses_rs2 = 1'b0;
        imm      = '0;
        // opcode sits at the same bits in both views
        case (instr.r.opcode)
            OPC_OP,
            OPC_OP_32: begin
                rs1      = instr.r.rs1;
                rs2      = instr.r.rs2;
                rd       = instr.r.rd;
                uses_rs2 = 1'b1;
            end
            OPC_OP_IMM,
            OPC_OP_IMM_32,
            OPC_LOAD: begin
                rs1 = instr.i.rs1;
                rd  = instr.i.rd;
                imm = {{(XLEN-12){instr.i.imm[11]}}, instr.i.imm}; // sext imm12
            end
            default: begin
                // unsupported formats keep the zero defaults
            end
        endcase
    end

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import rv_isa_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [REG_AW-1:0] raddr1,
    input  logic [REG_AW-1:0] raddr2,
    output logic [XLEN-1:0]   rdata1,
    output logic [XLEN-1:0]   rdata2,
    input  logic              we,
    input  logic [REG_AW-1:0] waddr,
    input  logic [XLEN-1:0]   wdata
);

    localparam int NREGS = 1 << REG_AW;

    logic [XLEN-1:0] regs [1:NREGS-1]; // no storage for x0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // WB forwarding covers the old value on a same-cycle write
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- hazard_detect.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_detect
    import rv_isa_pkg::*;
(
    input  logic              id_valid,
    input  logic [REG_AW-1:0] rs1,
    input  logic [REG_AW-1:0] rs2,
    input  logic              uses_rs2,
    input  logic              ex_we,
    input  logic              ex_is_load,
    input  logic [REG_AW-1:0] ex_rd,
    output logic              stall
);

    logic load_in_ex;
    logic hit_rs1;
    logic hit_rs2;

    // load data only shows up in MEM, so one cycle is lost
    assign load_in_ex = ex_we && ex_is_load && (ex_rd != '0);

    assign hit_rs1 = (ex_rd == rs1);
    assign hit_rs2 = uses_rs2 && (ex_rd == rs2); // I-type has no rs2

    assign stall = id_valid && load_in_ex && (hit_rs1 || hit_rs2);

endmodule

`default_nettype wire

//--- forward_mux.sv
`timescale 1ns/1ps
`default_nettype none

module forward_mux
    import rv_isa_pkg::*;
    import fwd_pkg::*;
(
    input  logic [REG_AW-1:0] rs1,
    input  logic [REG_AW-1:0] rs2,
    input  logic              uses_rs2,
    input  logic [XLEN-1:0]   rf_rdata1,
    input  logic [XLEN-1:0]   rf_rdata2,
    input  logic              ex_we,
    input  logic [REG_AW-1:0] ex_rd,
    input  logic [EXT_W-1:0]  ex_ext,
    input  logic [XLEN-1:0]   ex_result,
    input  logic              mem_we,
    input  logic [REG_AW-1:0] mem_rd,
    input  logic [XLEN-1:0]   mem_result,
    input  logic              wb_we,
    input  logic [REG_AW-1:0] wb_rd,
    input  logic [XLEN-1:0]   wb_result,
    output logic [XLEN-1:0]   rs1_val,
    output logic [XLEN-1:0]   rs2_val,
    output logic [SRC_W-1:0]  rs1_src,
    output logic [SRC_W-1:0]  rs2_src
);

    logic [XLEN-1:0] ex_val;

    // widen narrow EX results before they are forwarded
    always_comb begin
        case (ex_ext)
            EXT_WORD_S: ex_val = {{(XLEN-32){ex_result[31]}}, ex_result[31:0]};
            EXT_WORD_Z: ex_val = {{(XLEN-32){1'b0}}, ex_result[31:0]};
            EXT_HALF_S: ex_val = {{(XLEN-16){ex_result[15]}}, ex_result[15:0]};
            default:    ex_val = ex_result;
        endcase
    end

    // youngest producer first
    function automatic logic [SRC_W-1:0] pick_src(input logic [REG_AW-1:0] addr);
        logic [SRC_W-1:0] src;
        if (addr == '0) begin
            src = SRC_ZERO;
        end else if (ex_we && ex_rd == addr) begin
            src = SRC_EX;
        end else if (mem_we && mem_rd == addr) begin
            src = SRC_MEM;
        end else if (wb_we && wb_rd == addr) begin
            src = SRC_WB;
        end else begin
            src = SRC_RF;
        end
        return src;
    endfunction

    function automatic logic [XLEN-1:0] src_val(input logic [SRC_W-1:0] src,
                                                input logic [XLEN-1:0]  rf_val);
        logic [XLEN-1:0] val;
        case (src)
            SRC_EX:  val = ex_val;
            SRC_MEM: val = mem_result;
            SRC_WB:  val = wb_result;
            SRC_RF:  val = rf_val;
            default: val = '0;
        endcase
        return val;
    endfunction

    always_comb begin
        rs1_src = pick_src(rs1);
        rs2_src = uses_rs2 ? pick_src(rs2) : SRC_ZERO; // unused rs2 reads zero
        rs1_val = src_val(rs1_src, rf_rdata1);
        rs2_val = src_val(rs2_src, rf_rdata2);
    end

endmodule

`default_nettype wire

//--- issue_reg.sv
`timescale 1ns/1ps
`default_nettype none

module issue_reg
    import rv_isa_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              accept,
    input  logic [REG_AW-1:0] rd,
    input  logic [XLEN-1:0]   rs1_val,
    input  logic [XLEN-1:0]   rs2_val,
    input  logic [XLEN-1:0]   imm,
    output logic              iss_valid,
    output logic [REG_AW-1:0] iss_rd,
    output logic [XLEN-1:0]   iss_rs1_val,
    output logic [XLEN-1:0]   iss_rs2_val,
    output logic [XLEN-1:0]   iss_imm
);

    // valid and rd form the bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iss_valid <= 1'b0;
            iss_rd    <= '0;
        end else if (accept) begin
            iss_valid <= 1'b1;
            iss_rd    <= rd;
        end else begin
            iss_valid <= 1'b0;
            iss_rd    <= '0; // no write target
        end
    end

    // operands hold across a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iss_rs1_val <= '0;
            iss_rs2_val <= '0;
            iss_imm     <= '0;
        end else if (accept) begin
            iss_rs1_val <= rs1_val;
            iss_rs2_val <= rs2_val;
            iss_imm     <= imm;
        end
    end

endmodule

`default_nettype wire

//--- operand_supply_top.sv
`timescale 1ns/1ps
`default_nettype none

module operand_supply_top
    import rv_isa_pkg::*;
    import fwd_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               id_valid,
    input  logic [INSTR_W-1:0] id_instr,
    input  logic               ex_we,
    input  logic [REG_AW-1:0]  ex_rd,
    input  logic               ex_is_load,
    input  logic [EXT_W-1:0]   ex_ext,
    input  logic [XLEN-1:0]    ex_result,
    input  logic               mem_we,
    input  logic [REG_AW-1:0]  mem_rd,
    input  logic [XLEN-1:0]    mem_result,
    input  logic               wb_we,
    input  logic [REG_AW-1:0]  wb_rd,
    input  logic [XLEN-1:0]    wb_result,
    output logic               stall,
    output logic               iss_valid,
    output logic [REG_AW-1:0]  iss_rd,
    output logic [XLEN-1:0]    iss_rs1_val,
    output logic [XLEN-1:0]    iss_rs2_val,
    output logic [XLEN-1:0]    iss_imm
);

    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rd;
    logic              uses_rs2;
    logic [XLEN-1:0]   imm;
    logic [XLEN-1:0]   rf_rdata1;
    logic [XLEN-1:0]   rf_rdata2;
    logic [XLEN-1:0]   rs1_val;
    logic [XLEN-1:0]   rs2_val;
    logic [SRC_W-1:0]  rs1_src; // observed by bound checks
    logic [SRC_W-1:0]  rs2_src;
    logic              accept;

    assign accept = id_valid & ~stall;

    operand_decode u_decode (
        .instr(id_instr), .rs1(rs1), .rs2(rs2), .rd(rd), .uses_rs2(uses_rs2), .imm(imm)
    );

    reg_file u_rf (
        .clk(clk), .rst_n(rst_n),
        .raddr1(rs1), .raddr2(rs2), .rdata1(rf_rdata1), .rdata2(rf_rdata2),
        .we(wb_we), .waddr(wb_rd), .wdata(wb_result) // WB retires here
    );

    hazard_detect u_hazard (
        .id_valid(id_valid), .rs1(rs1), .rs2(rs2), .uses_rs2(uses_rs2),
        .ex_we(ex_we), .ex_is_load(ex_is_load), .ex_rd(ex_rd), .stall(stall)
    );

    forward_mux u_fwd (
        .rs1(rs1), .rs2(rs2), .uses_rs2(uses_rs2),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .ex_we(ex_we), .ex_rd(ex_rd), .ex_ext(ex_ext), .ex_result(ex_result),
        .mem_we(mem_we), .mem_rd(mem_rd), .mem_result(mem_result),
        .wb_we(wb_we), .wb_rd(wb_rd), .wb_result(wb_result),
        .rs1_val(rs1_val), .rs2_val(rs2_val), .rs1_src(rs1_src), .rs2_src(rs2_src)
    );

    issue_reg u_issue (
        .clk(clk), .rst_n(rst_n), .accept(accept),
        .rd(rd), .rs1_val(rs1_val), .rs2_val(rs2_val), .imm(imm),
        .iss_valid(iss_valid), .iss_rd(iss_rd),
        .iss_rs1_val(iss_rs1_val), .iss_rs2_val(iss_rs2_val), .iss_imm(iss_imm)
    );

endmodule

`default_nettype wire

//--- operand_supply_assert.sv
`timescale 1ns/1ps
`default_nettype none

module operand_supply_assert
    import rv_isa_pkg::*;
    import fwd_pkg::*;
(
    input logic              clk,
    input logic              rst_n,
    input logic              id_valid,
    input logic              stall,
    input logic              iss_valid,
    input logic [REG_AW-1:0] rs1,
    input logic [REG_AW-1:0] rs2,
    input logic [SRC_W-1:0]  rs1_src,
    input logic [SRC_W-1:0]  rs2_src
);

    bubble_after_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (id_valid && stall) |=> !iss_valid)
        else $error("issue register valid after a stalled cycle");

    // x0 is never forwarded
    zero_addr_rs1: assert property (@(posedge clk) disable iff (!rst_n)
        (rs1 == '0) |-> (rs1_src == SRC_ZERO))
        else $error("rs1 address zero not served as zero");

    zero_addr_rs2: assert property (@(posedge clk) disable iff (!rst_n)
        (rs2 == '0) |-> (rs2_src == SRC_ZERO))
        else $error("rs2 address zero not served as zero");

    reset_clears_valid: assert property (@(posedge clk) !rst_n |-> !iss_valid)
        else $error("issue register valid during reset");

endmodule

bind operand_supply_top operand_supply_assert u_assert (
    .clk(clk), .rst_n(rst_n), .id_valid(id_valid), .stall(stall), .iss_valid(iss_valid),
    .rs1(rs1), .rs2(rs2), .rs1_src(rs1_src), .rs2_src(rs2_src)
);

`default_nettype wire

//--- tb_operand_supply.sv
`timescale 1ns/1ps
`default_nettype none

module tb_operand_supply
    import rv_isa_pkg::*;
    import fwd_pkg::*;
();

    localparam int ACCEPT_TIMEOUT = 20;

    logic               clk;
    logic               rst_n;
    logic               id_valid;
    logic [INSTR_W-1:0] id_instr;
    logic               ex_we;
    logic [REG_AW-1:0]  ex_rd;
    logic               ex_is_load;
    logic [EXT_W-1:0]   ex_ext;
    logic [XLEN-1:0]    ex_result;
    logic               mem_we;
    logic [REG_AW-1:0]  mem_rd;
    logic [XLEN-1:0]    mem_result;
    logic               wb_we;
    logic [REG_AW-1:0]  wb_rd;
    logic [XLEN-1:0]    wb_result;
    logic               stall;
    logic               iss_valid;
    logic [REG_AW-1:0]  iss_rd;
    logic [XLEN-1:0]    iss_rs1_val;
    logic [XLEN-1:0]    iss_rs2_val;
    logic [XLEN-1:0]    iss_imm;
    logic [XLEN-1:0]    shadow [0:31]; // expected register file contents
    int                 seed;

    operand_supply_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                shadow[i] <= '0;
            end
        end else if (wb_we && wb_rd != '0) begin
            shadow[wb_rd] <= wb_result; // x0 stays zero
        end
    end

    function automatic logic [XLEN-1:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic [XLEN-1:0] extended(input logic [XLEN-1:0] res,
                                                 input logic [EXT_W-1:0] ext);
        case (ext)
            EXT_WORD_S: return {{32{res[31]}}, res[31:0]};
            EXT_WORD_Z: return {32'd0, res[31:0]};
            EXT_HALF_S: return {{48{res[15]}}, res[15:0]};
            default:    return res;
        endcase
    endfunction

    // newest producer first, register file last
    function automatic logic [XLEN-1:0] expected_operand(input logic [REG_AW-1:0] addr);
        if (addr == '0)
            return '0;
        if (ex_we && ex_rd == addr)
            return extended(ex_result, ex_ext);
        if (mem_we && mem_rd == addr)
            return mem_result;
        if (wb_we && wb_rd == addr)
            return wb_result;
        return shadow[addr];
    endfunction

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [XLEN-1:0] got,
                                   input logic [XLEN-1:0] exp);
        $display("Mismatch %s: got %h, expected %h", name, got, exp);
        abort_run();
    endtask

    task automatic report_error(input string msg);
        $display("Error: %s", msg);
        abort_run();
    endtask

    task automatic drive_idle();
        id_valid   = 1'b0;
        ex_we      = 1'b0;
        ex_is_load = 1'b0;
        ex_ext     = EXT_NONE;
        mem_we     = 1'b0;
        wb_we      = 1'b0;
    endtask

    task automatic check_bubble();
        assert (iss_valid === 1'b0)
            else report_mismatch("iss_valid", XLEN'(iss_valid), '0);
        assert (iss_rd === '0)
            else report_mismatch("iss_rd", XLEN'(iss_rd), '0);
    endtask

    task automatic check_issue(input logic [REG_AW-1:0] rd, input logic [XLEN-1:0] rs1_val,
                               input logic [XLEN-1:0] rs2_val, input logic [XLEN-1:0] imm);
        assert (iss_valid === 1'b1)
            else report_mismatch("iss_valid", XLEN'(iss_valid), 64'd1);
        assert (iss_rd === rd)
            else report_mismatch("iss_rd", XLEN'(iss_rd), XLEN'(rd));
        assert (iss_rs1_val === rs1_val)
            else report_mismatch("iss_rs1_val", iss_rs1_val, rs1_val);
        assert (iss_rs2_val === rs2_val)
            else report_mismatch("iss_rs2_val", iss_rs2_val, rs2_val);
        assert (iss_imm === imm)
            else report_mismatch("iss_imm", iss_imm, imm);
    endtask

    // returns at the edge that takes the instruction
    task automatic wait_accept();
        bit taken;
        int stalls;
        taken  = 1'b0;
        stalls = 0;
        while (!taken) begin
            @(posedge clk);
            if (!stall) begin
                taken = 1'b1;
            end else begin
                stalls++;
                if (stalls >= ACCEPT_TIMEOUT)
                    report_error("instruction still held by stall after timeout");
            end
        end
    endtask

    task automatic finish_issue(input logic [REG_AW-1:0] rd, input logic [XLEN-1:0] rs1_val,
                                input logic [XLEN-1:0] rs2_val, input logic [XLEN-1:0] imm);
        wait_accept();
        @(negedge clk);
        id_valid = 1'b0;
        check_issue(rd, rs1_val, rs2_val, imm);
    endtask

    task automatic issue_r(input logic [REG_AW-1:0] rd, input logic [REG_AW-1:0] rs1,
                           input logic [REG_AW-1:0] rs2);
        id_valid = 1'b1;
        id_instr = {7'd0, rs2, rs1, 3'd0, rd, OPC_OP};
        finish_issue(rd, expected_operand(rs1), expected_operand(rs2), '0);
    endtask

    task automatic issue_i(input logic [6:0] opc, input logic [REG_AW-1:0] rd,
                           input logic [REG_AW-1:0] rs1, input logic [11:0] imm);
        id_valid = 1'b1;
        id_instr = {imm, rs1, 3'd0, rd, opc};
        finish_issue(rd, expected_operand(rs1), '0, {{52{imm[11]}}, imm});
    endtask

    task automatic write_reg(input logic [REG_AW-1:0] addr, input logic [XLEN-1:0] data);
        wb_we     = 1'b1;
        wb_rd     = addr;
        wb_result = data;
        @(negedge clk);
        wb_we = 1'b0;
    endtask

    task automatic read_all_regs();
        for (int r = 0; r < 32; r += 2) begin
            issue_r(5'(r + 7), 5'(r), 5'(r + 1));
        end
    endtask

    // held R-type takes x5 from MEM once the load in EX moves on
    task automatic stall_on_load(input logic [REG_AW-1:0] rs1, input logic [REG_AW-1:0] rs2);
        ex_we      = 1'b1;
        ex_is_load = 1'b1;
        ex_rd      = 5'd5;
        ex_result  = rand64();
        id_valid   = 1'b1;
        id_instr   = {7'd0, rs2, rs1, 3'd0, 5'd24, OPC_OP};
        @(posedge clk);
        assert (stall === 1'b1)
            else report_mismatch("stall", XLEN'(stall), 64'd1);
        @(negedge clk);
        check_bubble();
        ex_we      = 1'b0;
        ex_is_load = 1'b0;
        mem_we     = 1'b1;
        mem_rd     = 5'd5;
        mem_result = rand64();
        finish_issue(5'd24, expected_operand(rs1), expected_operand(rs2), '0);
        mem_we = 1'b0;
    endtask

    task automatic test_reset_and_regs();
        check_bubble();
        assert (iss_rs1_val === '0)
            else report_mismatch("iss_rs1_val", iss_rs1_val, '0);
        assert (iss_rs2_val === '0)
            else report_mismatch("iss_rs2_val", iss_rs2_val, '0);
        assert (iss_imm === '0)
            else report_mismatch("iss_imm", iss_imm, '0);
        for (int r = 1; r < 32; r++) begin
            write_reg(5'(r), rand64());
        end
        write_reg(5'd0, rand64()); // must be dropped
        read_all_regs();
    endtask

    task automatic test_ex_extension();
        ex_we = 1'b1;
        ex_rd = 5'd10;
        for (int e = 0; e < 4; e++) begin
            ex_ext    = EXT_W'(e);
            ex_result = rand64() | 64'h0000_0000_8000_8000; // negative word and half
            issue_r(5'd20, 5'd10, 5'd11);
            ex_result = rand64() & ~64'h0000_0000_8000_8000;
            issue_r(5'd21, 5'd11, 5'd10);
        end
        drive_idle();
    endtask

    task automatic test_priority();
        ex_we      = 1'b1;
        ex_rd      = 5'd12;
        ex_result  = rand64();
        mem_we     = 1'b1;
        mem_rd     = 5'd12;
        mem_result = rand64();
        wb_we      = 1'b1;
        wb_rd      = 5'd12;
        wb_result  = rand64();
        issue_r(5'd22, 5'd12, 5'd13);
        ex_we = 1'b0;
        issue_r(5'd22, 5'd13, 5'd12);
        mem_we    = 1'b0;
        wb_result = rand64(); // differs from what x12 now holds
        issue_r(5'd22, 5'd12, 5'd12);
        wb_we = 1'b0;
        issue_r(5'd22, 5'd12, 5'd13);
    endtask

    task automatic test_load_use();
        stall_on_load(5'd5, 5'd6);
        stall_on_load(5'd8, 5'd5);
        ex_we      = 1'b1;
        ex_is_load = 1'b1;
        ex_rd      = 5'd5;
        issue_i(OPC_LOAD, 5'd25, 5'd9, 12'h005); // imm bits sit where rs2 would
        drive_idle();
    endtask

    task automatic test_itype_decode();
        issue_i(OPC_OP_IMM, 5'd14, 5'd3, 12'h3a5);
        issue_i(OPC_OP_IMM, 5'd15, 5'd4, 12'h85c);
        issue_i(OPC_OP_IMM_32, 5'd16, 5'd30, 12'hfff);
        issue_i(OPC_LOAD, 5'd17, 5'd31, 12'h7ff);
    endtask

    task automatic test_idle_cycle();
        id_valid = 1'b0;
        id_instr = {7'd0, 5'd2, 5'd1, 3'd0, 5'd26, OPC_OP};
        repeat (3) begin
            @(negedge clk);
            check_bubble();
        end
        read_all_regs();
    endtask

    initial begin
        seed       = 32'hb0e9_a159;
        rst_n      = 1'b0;
        id_instr   = '0;
        ex_rd      = '0;
        ex_result  = '0;
        mem_rd     = '0;
        mem_result = '0;
        wb_rd      = '0;
        wb_result  = '0;
        drive_idle();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset_and_regs();
        test_ex_extension();
        test_priority();
        test_load_use();
        test_itype_decode();
        test_idle_cycle();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
rv_isa_pkg.sv
fwd_pkg.sv
operand_decode.sv
reg_file.sv
hazard_detect.sv
forward_mux.sv
issue_reg.sv
operand_supply_top.sv
operand_supply_assert.sv
tb_operand_supply.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the operand supply testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_operand_supply \
    -f vlog.f \
    -o sim_operand_supply

./obj_dir/sim_operand_supply
